// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vinsn_sequencer
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
seq_pkg.sv
vinsn_tracker.sv
vreg_scoreboard.sv
unit_credits.sv
issue_ctrl.sv
vinsn_sequencer.sv
tb_vinsn_sequencer.sv

// File: issue_ctrl.sv
// Issue control and dispatcher handshake

`timescale 1ns/1ps

module issue_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Dispatcher request
  input  logic                          req_valid_i,
  input  seq_pkg::op_e                  req_op_i,
  input  seq_pkg::vreg_t                req_vs1_i,
  input  logic                          req_use_vs1_i,
  input  seq_pkg::vreg_t                req_vs2_i,
  input  logic                          req_use_vs2_i,
  input  seq_pkg::vreg_t                req_vd_i,
  input  logic                          req_use_vd_i,
  output logic                          req_ready_o,
  // Memory response
  output logic                          resp_valid_o,
  output logic                          resp_error_o,
  // Unit side
  input  logic [seq_pkg::NR_UNITS-1:0]  pe_req_ready_i,
  input  logic                          mem_ack_i,
  input  logic                          mem_error_i,
  output logic                          pe_req_valid_o,
  output seq_pkg::vid_t                 pe_req_id_o,
  output seq_pkg::op_e                  pe_req_op_o,
  output seq_pkg::unit_e                pe_req_unit_o,
  output seq_pkg::vreg_t                pe_req_vs1_o,
  output seq_pkg::vreg_t                pe_req_vs2_o,
  output seq_pkg::vreg_t                pe_req_vd_o,
  output seq_pkg::vinsn_mask_t          pe_req_hazard_o,
  // Tracker, credits and scoreboard
  input  seq_pkg::vid_t                 next_id_i,
  input  logic                          id_avail_i,
  input  logic                          room_i,
  input  seq_pkg::vinsn_mask_t          hazard_i,
  output seq_pkg::unit_e                unit_sel_o,
  output logic                          issue_o
);

  import seq_pkg::*;

  seq_state_e state_d, state_q;

  logic pe_req_pending;
  logic is_mem;

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  // Target unit of the request at the inputs
  assign unit_sel_o = op_unit(req_op_i);
  assign is_mem     = (unit_sel_o == UNIT_LOAD) || (unit_sel_o == UNIT_STORE);

  // Registered request not yet taken by its unit
  assign pe_req_pending = pe_req_valid_o && !pe_req_ready_i[pe_req_unit_o];

  // Needs a free slot everywhere and no memory op outstanding
  assign req_ready_o = !pe_req_pending && (state_q == ST_IDLE) && id_avail_i && room_i;
  assign issue_o     = req_valid_i && req_ready_o;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    resp_valid_o = 1'b0;
    unique case (state_q)
      ST_IDLE: begin
        // Loads and stores wait for the address generator
        if (issue_o && is_mem) state_d = ST_WAIT;
      end
      ST_WAIT: begin
        if (mem_ack_i) begin
          resp_valid_o = 1'b1;
          state_d      = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Error flag only travels with the response
  assign resp_error_o = resp_valid_o & mem_error_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Unit request
  //////////////////////////////////////////////////

  // Valid drops once taken and stays up under back-pressure
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else if (issue_o) begin
      pe_req_valid_o <= 1'b1;
    end else if (!pe_req_pending) begin
      pe_req_valid_o <= 1'b0;
    end
  end

  // Fields load only on acceptance so they hold while pending
  always_ff @(posedge clk_i) begin
    if (issue_o) begin
      pe_req_id_o     <= next_id_i;
      pe_req_op_o     <= req_op_i;
      pe_req_unit_o   <= unit_sel_o;
      pe_req_vs1_o    <= req_vs1_i;
      pe_req_vs2_o    <= req_vs2_i;
      pe_req_vd_o     <= req_vd_i;
      pe_req_hazard_o <= hazard_i;
    end
  end

endmodule

// File: seq_pkg.sv
// Vector sequencer package

package seq_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Instruction IDs in flight
  localparam int unsigned NR_VINSN = 8;
  // Architectural vector registers
  localparam int unsigned NR_VREGS = 32;
  // ALU, multiplier, load unit, store unit
  localparam int unsigned NR_UNITS = 4;

  // Derived widths
  localparam int unsigned VID_W    = $clog2(NR_VINSN);
  localparam int unsigned VREG_W   = $clog2(NR_VREGS);
  localparam int unsigned CREDIT_W = 3;

  // Instruction queue depth of each unit indexed by unit_e
  localparam int unsigned QUEUE_DEPTH [NR_UNITS] = '{4, 2, 2, 2};

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [VID_W-1:0]    vid_t;
  typedef logic [VREG_W-1:0]   vreg_t;
  typedef logic [NR_VINSN-1:0] vinsn_mask_t;
  typedef logic [CREDIT_W-1:0] credit_t;

  // Functional units in QUEUE_DEPTH order
  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MUL   = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  // Vector operations
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_MUL   = 4'd4,
    OP_MACC  = 4'd5,
    OP_LOAD  = 4'd6,
    OP_STORE = 4'd7
  } op_e;

  // Issue FSM where WAIT holds the dispatcher for a memory ack
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_WAIT = 1'b1
  } seq_state_e;

  // Unit that executes a given operation
  function automatic unit_e op_unit(op_e op);
    unit_e unit;
    unique case (op)
      OP_MUL, OP_MACC: unit = UNIT_MUL;
      OP_LOAD:         unit = UNIT_LOAD;
      OP_STORE:        unit = UNIT_STORE;
      default:         unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

endpackage

// File: tb_vinsn_sequencer.sv
// Vector sequencer testbench

`timescale 1ns/1ps

module tb_vinsn_sequencer;

  import seq_pkg::*;

  localparam int unsigned NUM_INSN   = 400;
  localparam int unsigned SEED       = 94974;
  localparam int unsigned CLK_PERIOD = 20;
  localparam int unsigned DRIVE_DLY  = 2;

  logic clk_i = 1'b0;
  logic rst_ni;

  // Dispatcher side
  logic        req_valid_i;
  op_e         req_op_i;
  vreg_t       req_vs1_i, req_vs2_i, req_vd_i;
  logic        req_use_vs1_i, req_use_vs2_i, req_use_vd_i;
  logic        req_ready_o, resp_valid_o, resp_error_o;
  // Unit side
  logic                       pe_req_valid_o;
  vid_t                       pe_req_id_o;
  op_e                        pe_req_op_o;
  unit_e                      pe_req_unit_o;
  vreg_t                      pe_req_vs1_o, pe_req_vs2_o, pe_req_vd_o;
  vinsn_mask_t                pe_req_hazard_o;
  logic [NR_UNITS-1:0]        pe_req_ready_i;
  vinsn_mask_t [NR_UNITS-1:0] unit_done_i;
  logic                       mem_ack_i, mem_error_i;
  vinsn_mask_t [NR_VINSN-1:0] global_hazard_table_o;
  logic                       idle_o;

  //////////////////////////////////////////////////
  // Reference model state
  //////////////////////////////////////////////////

  vinsn_mask_t running_m;
  int unsigned cnt_m [NR_UNITS];
  vid_t        rd_id_m [NR_VREGS];
  vid_t        wr_id_m [NR_VREGS];
  logic        rd_vld_m [NR_VREGS];
  logic        wr_vld_m [NR_VREGS];
  vinsn_mask_t table_m [NR_VINSN];
  logic        wait_m;
  // Expected registered unit request
  logic        pe_valid_m;
  vid_t        pe_id_m;
  op_e         pe_op_m;
  unit_e       pe_unit_m;
  vreg_t       pe_vs1_m, pe_vs2_m, pe_vd_m;
  vinsn_mask_t pe_haz_m;

  // Unit and address generator models
  vid_t unit_q [NR_UNITS][$];
  int   agen_cnt;
  // Progress
  int   sent, mem_cnt, resp_cnt;
  logic req_pending;

  vinsn_sequencer UUT (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Errors found");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "Run aborted");
  endtask

  // Lowest ID not in the running set
  function automatic vid_t lowest_free(vinsn_mask_t run);
    for (int i = 0; i < NR_VINSN; i++) begin
      if (!run[i]) return vid_t'(i);
    end
    return '0;
  endfunction

  // Live writer of a register as a one-hot ID set
  function automatic vinsn_mask_t writer_mask(vreg_t r);
    vinsn_mask_t m;
    m = '0;
    if (wr_vld_m[r] && running_m[wr_id_m[r]]) m[wr_id_m[r]] = 1'b1;
    return m;
  endfunction

  function automatic vinsn_mask_t reader_mask(vreg_t r);
    vinsn_mask_t m;
    m = '0;
    if (rd_vld_m[r] && running_m[rd_id_m[r]]) m[rd_id_m[r]] = 1'b1;
    return m;
  endfunction

  // RAW on sources, WAR and WAW on the destination
  function automatic vinsn_mask_t expected_hazard();
    vinsn_mask_t h;
    h = '0;
    if (req_use_vs1_i) h |= writer_mask(req_vs1_i);
    if (req_use_vs2_i) h |= writer_mask(req_vs2_i);
    if (req_use_vd_i) h |= reader_mask(req_vd_i) | writer_mask(req_vd_i);
    return h;
  endfunction

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic drive_inputs();
    for (int u = 0; u < NR_UNITS; u++) begin
      pe_req_ready_i[u] = ($urandom % 3) != 0;
      unit_done_i[u]    = '0;
      // Oldest queued instruction retires first
      if (unit_q[u].size() > 0 && ($urandom % 4) == 0) unit_done_i[u][unit_q[u][0]] = 1'b1;
    end
    mem_ack_i   = 1'b0;
    mem_error_i = 1'b0;
    if (agen_cnt > 0) begin
      agen_cnt--;
      if (agen_cnt == 0) begin
        mem_ack_i   = 1'b1;
        mem_error_i = ($urandom % 2) == 1;
      end
    end
    // New instruction only once the previous one went in
    if (!req_pending && sent < NUM_INSN && ($urandom % 4) != 0) begin
      req_op_i      = op_e'(4'($urandom_range(7, 0)));
      req_vs1_i     = vreg_t'($urandom_range(7, 0));
      req_vs2_i     = vreg_t'($urandom_range(7, 0));
      req_vd_i      = vreg_t'($urandom_range(7, 0));
      req_use_vs1_i = ($urandom % 2) == 1;
      req_use_vs2_i = ($urandom % 2) == 1;
      req_use_vd_i  = ($urandom % 4) != 0;
      req_pending   = 1'b1;
    end
    req_valid_i = req_pending;
  endtask

  //////////////////////////////////////////////////
  // Per-cycle compare and model step
  //////////////////////////////////////////////////

  task automatic check_and_update();
    logic        exp_ready, accept, take, mem_op;
    unit_e       sel;
    vid_t        new_id;
    vinsn_mask_t haz, done_all;
    sel       = op_unit(req_op_i);
    new_id    = lowest_free(running_m);
    haz       = expected_hazard();
    mem_op    = (sel == UNIT_LOAD) || (sel == UNIT_STORE);
    exp_ready = !(pe_valid_m && !pe_req_ready_i[pe_unit_m]) && !wait_m &&
                (running_m != '1) && (cnt_m[sel] < QUEUE_DEPTH[sel]);

    check("idle_o", 64'(idle_o), 64'(running_m == '0));
    check("req_ready_o", 64'(req_ready_o), 64'(exp_ready));
    check("pe_req_valid_o", 64'(pe_req_valid_o), 64'(pe_valid_m));
    // Fields must also hold while the unit stalls
    if (pe_valid_m) begin
      check("pe_req_id_o", 64'(pe_req_id_o), 64'(pe_id_m));
      check("pe_req_op_o", 64'(pe_req_op_o), 64'(pe_op_m));
      check("pe_req_unit_o", 64'(pe_req_unit_o), 64'(pe_unit_m));
      check("pe_req_vs1_o", 64'(pe_req_vs1_o), 64'(pe_vs1_m));
      check("pe_req_vs2_o", 64'(pe_req_vs2_o), 64'(pe_vs2_m));
      check("pe_req_vd_o", 64'(pe_req_vd_o), 64'(pe_vd_m));
      check("pe_req_hazard_o", 64'(pe_req_hazard_o), 64'(pe_haz_m));
    end
    check("resp_valid_o", 64'(resp_valid_o), 64'(wait_m && mem_ack_i));
    if (wait_m && mem_ack_i) check("resp_error_o", 64'(resp_error_o), 64'(mem_error_i));
    for (int i = 0; i < NR_VINSN; i++) begin
      check($sformatf("global_hazard_table_o[%0d]", i), 64'(global_hazard_table_o[i]),
            64'(table_m[i]));
    end

    accept = req_valid_i && exp_ready;
    take   = pe_valid_m && pe_req_ready_i[pe_unit_m];

    // Retire before the unit queues take new IDs
    done_all = '0;
    for (int u = 0; u < NR_UNITS; u++) begin
      if (unit_done_i[u] != '0) begin
        void'(unit_q[u].pop_front());
        cnt_m[u]--;
      end
      done_all |= unit_done_i[u];
    end
    // Units take the request seen on the DUT outputs
    if (pe_req_valid_o && pe_req_ready_i[pe_req_unit_o]) begin
      unit_q[pe_req_unit_o].push_back(pe_req_id_o);
      if (pe_req_unit_o == UNIT_LOAD || pe_req_unit_o == UNIT_STORE) begin
        agen_cnt = $urandom_range(6, 1);
      end
    end
    for (int u = 0; u < NR_UNITS; u++) begin
      if (unit_q[u].size() > QUEUE_DEPTH[u]) begin
        fail_run($sformatf("unit %0d holds more instructions than its queue depth", u));
      end
    end
    if (wait_m && mem_ack_i) begin
      wait_m = 1'b0;
      resp_cnt++;
    end

    // Finished IDs drop out of the lists and the table
    for (int v = 0; v < NR_VREGS; v++) begin
      rd_vld_m[v] = rd_vld_m[v] && running_m[rd_id_m[v]];
      wr_vld_m[v] = wr_vld_m[v] && running_m[wr_id_m[v]];
    end
    for (int i = 0; i < NR_VINSN; i++) table_m[i] = table_m[i] & running_m;

    if (accept) begin
      if (req_use_vd_i) begin
        wr_id_m[req_vd_i]  = new_id;
        wr_vld_m[req_vd_i] = 1'b1;
      end
      if (req_use_vs1_i) begin
        rd_id_m[req_vs1_i]  = new_id;
        rd_vld_m[req_vs1_i] = 1'b1;
      end
      if (req_use_vs2_i) begin
        rd_id_m[req_vs2_i]  = new_id;
        rd_vld_m[req_vs2_i] = 1'b1;
      end
      table_m[new_id] = haz;
      pe_valid_m = 1'b1;
      pe_id_m    = new_id;
      pe_op_m    = req_op_i;
      pe_unit_m  = sel;
      pe_vs1_m   = req_vs1_i;
      pe_vs2_m   = req_vs2_i;
      pe_vd_m    = req_vd_i;
      pe_haz_m   = haz;
      if (mem_op) begin
        wait_m = 1'b1;
        mem_cnt++;
      end
      cnt_m[sel]++;
      sent++;
      req_pending = 1'b0;
    end else if (take) begin
      pe_valid_m = 1'b0;
    end
    running_m = running_m & ~done_all;
    if (accept) running_m[new_id] = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_op_i       = OP_ADD;
    req_vs1_i      = '0;
    req_vs2_i      = '0;
    req_vd_i       = '0;
    req_use_vs1_i  = 1'b0;
    req_use_vs2_i  = 1'b0;
    req_use_vd_i   = 1'b0;
    pe_req_ready_i = '0;
    unit_done_i    = '0;
    mem_ack_i      = 1'b0;
    mem_error_i    = 1'b0;
    running_m   = '0;
    wait_m      = 1'b0;
    pe_valid_m  = 1'b0;
    pe_id_m     = '0;
    pe_op_m     = OP_ADD;
    pe_unit_m   = UNIT_ALU;
    pe_vs1_m    = '0;
    pe_vs2_m    = '0;
    pe_vd_m     = '0;
    pe_haz_m    = '0;
    agen_cnt    = 0;
    sent        = 0;
    mem_cnt     = 0;
    resp_cnt    = 0;
    req_pending = 1'b0;
    for (int u = 0; u < NR_UNITS; u++) cnt_m[u] = 0;
    for (int v = 0; v < NR_VREGS; v++) begin
      rd_id_m[v]  = '0;
      wr_id_m[v]  = '0;
      rd_vld_m[v] = 1'b0;
      wr_vld_m[v] = 1'b0;
    end
    for (int i = 0; i < NR_VINSN; i++) table_m[i] = '0;

    repeat (4) @(posedge clk_i);
    #DRIVE_DLY;
    rst_ni = 1'b1;

    // Run until every instruction went in and retired
    while (sent < NUM_INSN || running_m != '0 || pe_valid_m || wait_m) begin
      drive_inputs();
      @(negedge clk_i);
      check_and_update();
      @(posedge clk_i);
      #DRIVE_DLY;
    end
    // One more cycle to see idle after the drain
    drive_inputs();
    @(negedge clk_i);
    check_and_update();

    if (resp_cnt != mem_cnt) begin
      fail_run($sformatf("%0d memory ops but %0d responses", mem_cnt, resp_cnt));
    end else begin
      $display("No errors");
      $finish;
    end
  end

  // Upper bound of 40 cycles per instruction
  initial begin
    #(NUM_INSN * 40 * CLK_PERIOD);
    fail_run("Watchdog expired before all instructions finished");
  end

endmodule

// File: unit_credits.sv
// Per-unit queue credit counters

`timescale 1ns/1ps

module unit_credits (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Issue to the selected unit
  input  logic                                         issue_i,
  input  seq_pkg::unit_e                               unit_sel_i,
  // Completion with one row per unit
  input  seq_pkg::vinsn_mask_t [seq_pkg::NR_UNITS-1:0] unit_done_i,
  // Selected unit can take another instruction
  output logic                                         room_o
);

  import seq_pkg::*;

  //////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////

  // Instructions held in each unit queue
  credit_t [NR_UNITS-1:0] cnt_q;

  logic [NR_UNITS-1:0] cnt_up, cnt_down;

  always_comb begin
    for (int u = 0; u < NR_UNITS; u++) begin
      cnt_up[u]   = issue_i && (unit_sel_i == unit_e'(u));
      // A unit retires at most one instruction per cycle
      cnt_down[u] = |unit_done_i[u];
    end
  end

  // Issue and retire in one cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int u = 0; u < NR_UNITS; u++) begin
        if (cnt_up[u] && !cnt_down[u]) begin
          cnt_q[u] <= cnt_q[u] + credit_t'(1);
        end else if (cnt_down[u] && !cnt_up[u]) begin
          cnt_q[u] <= cnt_q[u] - credit_t'(1);
        end
      end
    end
  end

  // Room check against the depth of the target unit
  assign room_o = cnt_q[unit_sel_i] < credit_t'(QUEUE_DEPTH[unit_sel_i]);

endmodule

// File: vinsn_sequencer.sv
// Vector instruction sequencer top

`timescale 1ns/1ps

module vinsn_sequencer (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Dispatcher
  input  logic                                         req_valid_i,
  input  seq_pkg::op_e                                 req_op_i,
  input  seq_pkg::vreg_t                               req_vs1_i,
  input  logic                                         req_use_vs1_i,
  input  seq_pkg::vreg_t                               req_vs2_i,
  input  logic                                         req_use_vs2_i,
  input  seq_pkg::vreg_t                               req_vd_i,
  input  logic                                         req_use_vd_i,
  output logic                                         req_ready_o,
  output logic                                         resp_valid_o,
  output logic                                         resp_error_o,
  // Functional units
  output logic                                         pe_req_valid_o,
  output seq_pkg::vid_t                                pe_req_id_o,
  output seq_pkg::op_e                                 pe_req_op_o,
  output seq_pkg::unit_e                               pe_req_unit_o,
  output seq_pkg::vreg_t                               pe_req_vs1_o,
  output seq_pkg::vreg_t                               pe_req_vs2_o,
  output seq_pkg::vreg_t                               pe_req_vd_o,
  output seq_pkg::vinsn_mask_t                         pe_req_hazard_o,
  input  logic [seq_pkg::NR_UNITS-1:0]                 pe_req_ready_i,
  input  seq_pkg::vinsn_mask_t [seq_pkg::NR_UNITS-1:0] unit_done_i,
  // Address generator
  input  logic                                         mem_ack_i,
  input  logic                                         mem_error_i,
  // Operand requesters and status
  output seq_pkg::vinsn_mask_t [seq_pkg::NR_VINSN-1:0] global_hazard_table_o,
  output logic                                         idle_o
);

  import seq_pkg::*;

  unit_e       unit_sel;
  logic        issue;
  vid_t        next_id;
  logic        id_avail;
  vinsn_mask_t vinsn_running;
  logic        room;
  vinsn_mask_t hazard;

  // Handshake, FSM and registered unit request
  issue_ctrl i_issue_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_vs1_i      (req_vs1_i),
    .req_use_vs1_i  (req_use_vs1_i),
    .req_vs2_i      (req_vs2_i),
    .req_use_vs2_i  (req_use_vs2_i),
    .req_vd_i       (req_vd_i),
    .req_use_vd_i   (req_use_vd_i),
    .req_ready_o    (req_ready_o),
    .resp_valid_o   (resp_valid_o),
    .resp_error_o   (resp_error_o),
    .pe_req_ready_i (pe_req_ready_i),
    .mem_ack_i      (mem_ack_i),
    .mem_error_i    (mem_error_i),
    .pe_req_valid_o (pe_req_valid_o),
    .pe_req_id_o    (pe_req_id_o),
    .pe_req_op_o    (pe_req_op_o),
    .pe_req_unit_o  (pe_req_unit_o),
    .pe_req_vs1_o   (pe_req_vs1_o),
    .pe_req_vs2_o   (pe_req_vs2_o),
    .pe_req_vd_o    (pe_req_vd_o),
    .pe_req_hazard_o(pe_req_hazard_o),
    .next_id_i      (next_id),
    .id_avail_i     (id_avail),
    .room_i         (room),
    .hazard_i       (hazard),
    .unit_sel_o     (unit_sel),
    .issue_o        (issue)
  );

  // ID allocation and running set
  vinsn_tracker i_vinsn_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_i        (issue),
    .unit_sel_i     (unit_sel),
    .unit_done_i    (unit_done_i),
    .next_id_o      (next_id),
    .id_avail_o     (id_avail),
    .vinsn_running_o(vinsn_running),
    .idle_o         (idle_o)
  );

  // RAW, WAR and WAW tracking
  vreg_scoreboard i_vreg_scoreboard (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .issue_i              (issue),
    .issue_id_i           (next_id),
    .req_vs1_i            (req_vs1_i),
    .req_vs2_i            (req_vs2_i),
    .req_vd_i             (req_vd_i),
    .req_use_vs1_i        (req_use_vs1_i),
    .req_use_vs2_i        (req_use_vs2_i),
    .req_use_vd_i         (req_use_vd_i),
    .vinsn_running_i      (vinsn_running),
    .hazard_o             (hazard),
    .global_hazard_table_o(global_hazard_table_o)
  );

  // Queue occupancy per unit
  unit_credits i_unit_credits (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .issue_i    (issue),
    .unit_sel_i (unit_sel),
    .unit_done_i(unit_done_i),
    .room_o     (room)
  );

endmodule

// File: vinsn_tracker.sv
// Running instruction tracker

`timescale 1ns/1ps

module vinsn_tracker (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Issue of a new instruction
  input  logic                                         issue_i,
  input  seq_pkg::unit_e                               unit_sel_i,
  // Completion with one row per unit
  input  seq_pkg::vinsn_mask_t [seq_pkg::NR_UNITS-1:0] unit_done_i,
  // ID allocation and status
  output seq_pkg::vid_t                                next_id_o,
  output logic                                         id_avail_o,
  output seq_pkg::vinsn_mask_t                         vinsn_running_o,
  output logic                                         idle_o
);

  import seq_pkg::*;

  //////////////////////////////////////////////////
  // Running matrix
  //////////////////////////////////////////////////

  // One row per unit where a set bit means that ID runs there
  vinsn_mask_t [NR_UNITS-1:0] running_d, running_q;

  // Collapse the rows into one running set
  always_comb begin
    vinsn_running_o = '0;
    for (int u = 0; u < NR_UNITS; u++) begin
      vinsn_running_o |= running_q[u];
    end
  end

  // Scan from the top so the lowest free ID wins
  always_comb begin
    next_id_o = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!vinsn_running_o[i]) next_id_o = vid_t'(i);
    end
  end

  // All IDs busy blocks the dispatcher
  assign id_avail_o = ~&vinsn_running_o;
  assign idle_o     = ~|vinsn_running_o;

  // Done bits retire and issue claims the free ID
  always_comb begin
    for (int u = 0; u < NR_UNITS; u++) begin
      running_d[u] = running_q[u] & ~unit_done_i[u];
    end
    if (issue_i) begin
      running_d[unit_sel_i][next_id_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

endmodule

// File: vreg_scoreboard.sv
// Vector register hazard scoreboard

`timescale 1ns/1ps

module vreg_scoreboard (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Instruction being accepted
  input  logic                                         issue_i,
  input  seq_pkg::vid_t                                issue_id_i,
  // Register operands of the request at the inputs
  input  seq_pkg::vreg_t                               req_vs1_i,
  input  seq_pkg::vreg_t                               req_vs2_i,
  input  seq_pkg::vreg_t                               req_vd_i,
  input  logic                                         req_use_vs1_i,
  input  logic                                         req_use_vs2_i,
  input  logic                                         req_use_vd_i,
  // Currently running IDs
  input  seq_pkg::vinsn_mask_t                         vinsn_running_i,
  // Dependencies of the request and of every running ID
  output seq_pkg::vinsn_mask_t                         hazard_o,
  output seq_pkg::vinsn_mask_t [seq_pkg::NR_VINSN-1:0] global_hazard_table_o
);

  import seq_pkg::*;

  //////////////////////////////////////////////////
  // Access lists
  //////////////////////////////////////////////////

  // Last reader and last writer of each register
  vid_t [NR_VREGS-1:0] rd_id_d, rd_id_q;
  vid_t [NR_VREGS-1:0] wr_id_d, wr_id_q;
  logic [NR_VREGS-1:0] rd_vld_d, rd_vld_q;
  logic [NR_VREGS-1:0] wr_vld_d, wr_vld_q;

  // Entries still backed by a running instruction
  logic [NR_VREGS-1:0] rd_vld_live, wr_vld_live;

  vinsn_mask_t [NR_VINSN-1:0] table_d;

  // A finished ID no longer counts as reader or writer
  always_comb begin
    for (int v = 0; v < NR_VREGS; v++) begin
      rd_vld_live[v] = rd_vld_q[v] & vinsn_running_i[rd_id_q[v]];
      wr_vld_live[v] = wr_vld_q[v] & vinsn_running_i[wr_id_q[v]];
    end
  end

  //////////////////////////////////////////////////
  // Hazard vector
  //////////////////////////////////////////////////

  always_comb begin
    hazard_o = '0;
    // RAW on the sources
    if (req_use_vs1_i) hazard_o[wr_id_q[req_vs1_i]] |= wr_vld_live[req_vs1_i];
    if (req_use_vs2_i) hazard_o[wr_id_q[req_vs2_i]] |= wr_vld_live[req_vs2_i];
    if (req_use_vd_i) begin
      // WAR on the destination
      hazard_o[rd_id_q[req_vd_i]] |= rd_vld_live[req_vd_i];
      // WAW on the destination
      hazard_o[wr_id_q[req_vd_i]] |= wr_vld_live[req_vd_i];
    end
  end

  // New instruction takes over the registers it touches
  always_comb begin
    rd_id_d  = rd_id_q;
    wr_id_d  = wr_id_q;
    rd_vld_d = rd_vld_live;
    wr_vld_d = wr_vld_live;
    if (issue_i) begin
      if (req_use_vd_i) begin
        wr_id_d[req_vd_i]  = issue_id_i;
        wr_vld_d[req_vd_i] = 1'b1;
      end
      if (req_use_vs1_i) begin
        rd_id_d[req_vs1_i]  = issue_id_i;
        rd_vld_d[req_vs1_i] = 1'b1;
      end
      if (req_use_vs2_i) begin
        rd_id_d[req_vs2_i]  = issue_id_i;
        rd_vld_d[req_vs2_i] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Global hazard table
  //////////////////////////////////////////////////

  // Row N lists the IDs that instruction N waits on
  always_comb begin
    for (int i = 0; i < NR_VINSN; i++) begin
      table_d[i] = global_hazard_table_o[i] & vinsn_running_i;
    end
    if (issue_i) table_d[issue_id_i] = hazard_o;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_vld_q              <= '0;
      wr_vld_q              <= '0;
      global_hazard_table_o <= '0;
    end else begin
      rd_vld_q              <= rd_vld_d;
      wr_vld_q              <= wr_vld_d;
      global_hazard_table_o <= table_d;
    end
  end

  // Owner ID of each list entry
  always_ff @(posedge clk_i) begin
    rd_id_q <= rd_id_d;
    wr_id_q <= wr_id_d;
  end

endmodule
